/* include/execute_config.svh */
// Widths are fixed for RV32I; changing XLEN alone does not make an RV64 datapath
`ifndef EXECUTE_CONFIG_SVH
`define EXECUTE_CONFIG_SVH

// Data and PC width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Sequential PC increment, no compressed instructions
`define INSTR_STEP 4

`endif

/* hw/rvIsaPkg.sv */
// ISA encodings for RV32I integer ops only; no M extension and no CSR operations
package rvIsaPkg;

    // Operation class from the main control unit
    typedef enum logic [1:0] {
        ALUOP_LS     = 2'b00,   // Load/store address add
        ALUOP_BRANCH = 2'b01,   // Branch compare
        ALUOP_RTYPE  = 2'b10,   // Register-register
        ALUOP_ITYPE  = 2'b11    // Register-immediate
    } aluOpT;

    // Operation actually performed by the ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,        // Signed less-than
        ALU_SLTU = 4'd9         // Unsigned less-than
    } aluCtrlT;

    // Branch condition as encoded in funct3
    // 3'b010 and 3'b011 are not branch encodings
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchFunctT;

endpackage

/* hw/exPipePkg.sv */
// Pipeline bundles leaving the execute stage; field order sets the packed layout
`include "execute_config.svh"

package exPipePkg;

    // Forwarding source for an operand, chosen by the external hazard unit
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,       // Register file read data
        FWD_MEMWB = 2'd1,       // Result from MEM/WB
        FWD_EXMEM = 2'd2        // Result from EX/MEM
    } fwdSelT;

    // Payload toward the memory stage, 105 bits
    typedef struct packed {
        logic [`XLEN-1:0]       pc;         // PC of the instruction
        logic [`XLEN-1:0]       result;     // ALU result or link value
        logic [`XLEN-1:0]       storeData;  // Forwarded rs2 for stores
        logic [`REG_ADDR_W-1:0] rd;         // Destination register
        logic                   memRead;
        logic                   memWrite;
        logic                   memToReg;
        logic                   regWrite;
    } exMemT;

    // Payload toward fetch and the predictor, 35 bits
    typedef struct packed {
        logic             branchInst;   // Conditional branch resolved
        logic             taken;        // Actual outcome
        logic             mispredict;   // Outcome differs from prediction
        logic [`XLEN-1:0] nextPc;       // Fetch restart address, zero if none
    } redirectT;

endpackage

/* hw/aluIf.sv */
// Purely combinational link between the stage and the ALU; no handshake and no clock
`timescale 1ns/1ns
`include "execute_config.svh"

interface aluIf;
    import rvIsaPkg::*;

    aluCtrlT          aluCtrl;  // Decoded operation
    logic [`XLEN-1:0] a;        // Operand A after forwarding
    logic [`XLEN-1:0] b;        // Operand B, immediate or forwarded rs2
    logic [`XLEN-1:0] result;
    logic             zero;     // Result equals zero

    // Stage side drives control and operands
    modport stage (
        output aluCtrl, a, b,
        input  result, zero
    );

    // ALU side returns the result
    modport alu (
        input  aluCtrl, a, b,
        output result, zero
    );

endinterface

/* hw/aluDecoder.sv */
// Combinational decode; funct7 bit 5 is the only funct7 bit looked at
`timescale 1ns/1ns

module aluDecoder (
    input  rvIsaPkg::aluOpT   aluOp,    // Class from control unit
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    output rvIsaPkg::aluCtrlT aluCtrl
);
    import rvIsaPkg::*;

    logic altBit;   // SUB / SRA selector

    assign altBit = funct7[5];

    always_comb begin
        aluCtrl = ALU_ADD;                                  // Default add
        case (aluOp)
            ALUOP_LS:     aluCtrl = ALU_ADD;                // Address calculation
            ALUOP_BRANCH: aluCtrl = ALU_SUB;                // Compare by subtract
            ALUOP_RTYPE,
            ALUOP_ITYPE: begin
                case (funct3)
                    3'b000: begin
                        // ADDI never subtracts, so only R-type looks at funct7
                        if (aluOp == ALUOP_RTYPE && altBit) begin
                            aluCtrl = ALU_SUB;
                        end else begin
                            aluCtrl = ALU_ADD;
                        end
                    end
                    3'b001: aluCtrl = ALU_SLL;
                    3'b010: aluCtrl = ALU_SLT;
                    3'b011: aluCtrl = ALU_SLTU;
                    3'b100: aluCtrl = ALU_XOR;
                    3'b101: aluCtrl = altBit ? ALU_SRA : ALU_SRL;   // SRAI shares the bit
                    3'b110: aluCtrl = ALU_OR;
                    3'b111: aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD;
                endcase
            end
            default: aluCtrl = ALU_ADD;
        endcase
    end

endmodule

/* hw/alu.sv */
// RV32I integer ALU, combinational; shifts use only the low five bits of b
`timescale 1ns/1ns
`include "execute_config.svh"

module alu (
    aluIf.alu bus   // Control and operands in, result out
);
    import rvIsaPkg::*;

    logic [4:0]       shamt;    // Shift amount
    logic             ltSigned;
    logic             ltUnsigned;
    logic [`XLEN-1:0] res;

    assign shamt      = bus.b[4:0];
    assign ltSigned   = $signed(bus.a) < $signed(bus.b);
    assign ltUnsigned = bus.a < bus.b;

    always_comb begin
        case (bus.aluCtrl)
            ALU_ADD:  res = bus.a + bus.b;
            ALU_SUB:  res = bus.a - bus.b;
            ALU_AND:  res = bus.a & bus.b;
            ALU_OR:   res = bus.a | bus.b;
            ALU_XOR:  res = bus.a ^ bus.b;
            ALU_SLL:  res = bus.a << shamt;
            ALU_SRL:  res = bus.a >> shamt;
            ALU_SRA:  res = $unsigned($signed(bus.a) >>> shamt);   // Sign fill
            ALU_SLT:  res = {{(`XLEN-1){1'b0}}, ltSigned};
            ALU_SLTU: res = {{(`XLEN-1){1'b0}}, ltUnsigned};
            default:  res = '0;
        endcase
    end

    assign bus.result = res;
    assign bus.zero   = (res == '0);    // Zero flag

endmodule

/* hw/branchResolver.sv */
// Only PC-relative targets; JALR is not handled, and a jump mispredicts when predicted not taken
`timescale 1ns/1ns
`include "execute_config.svh"

module branchResolver (
    input  logic                  enable,         // Valid instruction in EX
    input  logic                  branch,         // Conditional branch
    input  logic                  jump,           // Unconditional jump
    input  rvIsaPkg::branchFunctT funct3,
    input  logic [`XLEN-1:0]      rs1,            // Forwarded operands
    input  logic [`XLEN-1:0]      rs2,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      imm,
    input  logic                  predictTaken,   // From the predictor via ID/EX
    output exPipePkg::redirectT   redirect
);
    import rvIsaPkg::*;
    import exPipePkg::*;

    logic             cond;         // Branch condition holds
    logic             taken;
    logic             active;       // Something to resolve this cycle
    logic             miss;
    logic [`XLEN-1:0] target;       // Taken address
    logic [`XLEN-1:0] fallThrough;  // Sequential address

    // Compare directly, independent of the ALU operation
    always_comb begin
        case (funct3)
            BR_BEQ:  cond = (rs1 == rs2);
            BR_BNE:  cond = (rs1 != rs2);
            BR_BLT:  cond = ($signed(rs1) < $signed(rs2));
            BR_BGE:  cond = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: cond = (rs1 < rs2);
            BR_BGEU: cond = (rs1 >= rs2);
            default: cond = 1'b0;       // Not a branch encoding
        endcase
    end

    assign active      = enable && (branch || jump);
    assign taken       = jump || (branch && cond);  // Jumps always taken
    assign miss        = taken != predictTaken;
    assign target      = pc + imm;
    assign fallThrough = pc + `XLEN'(`INSTR_STEP);

    always_comb begin
        redirect = '0;                                  // Idle: all zero
        if (active) begin
            redirect.branchInst = branch && !jump;      // Conditional only
            redirect.taken      = taken;
            redirect.mispredict = miss;
            if (miss) begin
                redirect.nextPc = taken ? target : fallThrough;
            end
        end
    end

endmodule

/* hw/stageReg.sv */
// Flush beats stall beats load; payload resets to zero so outputs are clean after reset
`timescale 1ns/1ns

module stageReg #(
    parameter type payloadT = logic    // Bundle carried by this register
) (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    flush,     // Clear payload and valid
    input  logic    stall,     // Hold payload, drop valid
    input  logic    load,      // Capture new payload
    input  payloadT dIn,
    output payloadT qOut,
    output logic    valid
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            qOut  <= '0;
            valid <= 1'b0;
        end else if (flush) begin
            qOut  <= '0;            // Squash
            valid <= 1'b0;
        end else if (stall) begin
            valid <= 1'b0;          // Payload held
        end else if (load) begin
            qOut  <= dIn;
            valid <= 1'b1;
        end else begin
            valid <= 1'b0;          // Bubble, payload held
        end
    end

endmodule

/* hw/executeStage.sv */
// Forwarding selects come from outside; upstream must hold its inputs while stall is high
`timescale 1ns/1ns
`include "execute_config.svh"

module executeStage (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   flush,          // From hazard unit
    input  logic                   stall,          // From hazard unit
    input  logic                   enable,         // Valid ID/EX contents
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       readData1,
    input  logic [`XLEN-1:0]       readData2,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [6:0]             funct7,
    input  logic [2:0]             funct3,
    input  logic                   aluSrc,         // B from immediate
    input  rvIsaPkg::aluOpT        aluOp,
    input  logic                   branch,
    input  logic                   jump,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic                   memToReg,
    input  logic                   regWrite,
    input  logic                   predictTaken,
    input  exPipePkg::fwdSelT      fwdA,
    input  exPipePkg::fwdSelT      fwdB,
    input  logic [`XLEN-1:0]       exMemFwd,       // EX/MEM result
    input  logic [`XLEN-1:0]       memWbFwd,       // MEM/WB result
    output exPipePkg::exMemT       exMem,
    output logic                   memValid,
    output exPipePkg::redirectT    redirect
);
    import rvIsaPkg::*;
    import exPipePkg::*;

    logic [`XLEN-1:0] opA;          // Forwarded rs1
    logic [`XLEN-1:0] rs2Fwd;       // Forwarded rs2
    logic [`XLEN-1:0] linkValue;    // Return address for jumps
    exMemT            exMemNext;
    redirectT         redirectNext;

    aluIf aluBus ();

    // Operand A source
    always_comb begin
        case (fwdA)
            FWD_EXMEM: opA = exMemFwd;
            FWD_MEMWB: opA = memWbFwd;
            default:   opA = readData1;
        endcase
    end

    // rs2 source, also used as store data
    always_comb begin
        case (fwdB)
            FWD_EXMEM: rs2Fwd = exMemFwd;
            FWD_MEMWB: rs2Fwd = memWbFwd;
            default:   rs2Fwd = readData2;
        endcase
    end

    assign aluBus.a   = opA;
    assign aluBus.b   = aluSrc ? imm : rs2Fwd;     // Immediate wins over forwarding
    assign linkValue  = pc + `XLEN'(`INSTR_STEP);

    aluDecoder uDecoder (
        .aluOp   (aluOp),
        .funct3  (funct3),
        .funct7  (funct7),
        .aluCtrl (aluBus.aluCtrl)
    );

    alu uAlu (
        .bus (aluBus.alu)
    );

    branchResolver uResolver (
        .enable       (enable),
        .branch       (branch),
        .jump         (jump),
        .funct3       (branchFunctT'(funct3)),
        .rs1          (opA),
        .rs2          (rs2Fwd),
        .pc           (pc),
        .imm          (imm),
        .predictTaken (predictTaken),
        .redirect     (redirectNext)
    );

    // Memory-stage bundle
    always_comb begin
        exMemNext.pc        = pc;
        exMemNext.result    = jump ? linkValue : aluBus.result;
        exMemNext.storeData = rs2Fwd;
        exMemNext.rd        = rd;
        exMemNext.memRead   = memRead;
        exMemNext.memWrite  = memWrite;
        exMemNext.memToReg  = memToReg;
        exMemNext.regWrite  = regWrite;
    end

    stageReg #(.payloadT(exMemT)) uMemReg (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (flush),
        .stall   (stall),
        .load    (enable),
        .dIn     (exMemNext),
        .qOut    (exMem),
        .valid   (memValid)
    );

    // Redirect loads each unstalled cycle; resolver zeroes it when idle
    stageReg #(.payloadT(redirectT)) uRedirReg (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (flush),
        .stall   (stall),
        .load    (1'b1),
        .dIn     (redirectNext),
        .qOut    (redirect),
        .valid   ()
    );

endmodule

/* hw/executeTop.sv */
// Top with flat ports; aluOp and forwarding selects are raw codes, 2'd3 forwards as register data
`timescale 1ns/1ns
`include "execute_config.svh"

module executeTop (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   enable,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       readData1,
    input  logic [`XLEN-1:0]       readData2,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [6:0]             funct7,
    input  logic [2:0]             funct3,
    input  logic                   aluSrc,
    input  logic [1:0]             aluOp,
    input  logic                   branch,
    input  logic                   jump,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic                   memToReg,
    input  logic                   regWrite,
    input  logic                   predictTaken,
    input  logic [1:0]             fwdA,
    input  logic [1:0]             fwdB,
    input  logic [`XLEN-1:0]       exMemFwd,
    input  logic [`XLEN-1:0]       memWbFwd,
    output logic [`XLEN-1:0]       memPc,
    output logic [`XLEN-1:0]       memResult,
    output logic [`XLEN-1:0]       memWriteData,
    output logic [`REG_ADDR_W-1:0] memRd,
    output logic                   memMemRead,
    output logic                   memMemWrite,
    output logic                   memMemToReg,
    output logic                   memRegWrite,
    output logic                   memValid,
    output logic                   branchInst,
    output logic                   branchTaken,
    output logic                   mispredict,
    output logic [`XLEN-1:0]       nextPc
);
    import rvIsaPkg::*;
    import exPipePkg::*;

    exMemT    exMem;      // Registered memory bundle
    redirectT redirect;   // Registered redirect bundle

    executeStage uStage (
        .clk (clk), .reset_n (reset_n),
        .flush (flush), .stall (stall), .enable (enable),
        .pc (pc), .readData1 (readData1), .readData2 (readData2), .imm (imm),
        .rd (rd), .funct7 (funct7), .funct3 (funct3), .aluSrc (aluSrc),
        .aluOp (aluOpT'(aluOp)), .branch (branch), .jump (jump),
        .memRead (memRead), .memWrite (memWrite), .memToReg (memToReg),
        .regWrite (regWrite), .predictTaken (predictTaken),
        .fwdA (fwdSelT'(fwdA)), .fwdB (fwdSelT'(fwdB)),
        .exMemFwd (exMemFwd), .memWbFwd (memWbFwd),
        .exMem (exMem), .memValid (memValid), .redirect (redirect)
    );

    // Unpack the memory bundle
    assign memPc        = exMem.pc;
    assign memResult    = exMem.result;
    assign memWriteData = exMem.storeData;
    assign memRd        = exMem.rd;
    assign memMemRead   = exMem.memRead;
    assign memMemWrite  = exMem.memWrite;
    assign memMemToReg  = exMem.memToReg;
    assign memRegWrite  = exMem.regWrite;

    // Unpack the redirect bundle
    assign branchInst  = redirect.branchInst;
    assign branchTaken = redirect.taken;
    assign mispredict  = redirect.mispredict;
    assign nextPc      = redirect.nextPc;

endmodule

/* test/tbExecute.sv */
// Random test of executeTop against an in-bench model; one instruction per cycle, 3000 cycles
`timescale 1ns/1ns
`include "execute_config.svh"

module tbExecute;
    import rvIsaPkg::*;

    localparam int NUM_CYCLES = 3000;       // Random instructions issued

    logic clk = 1'b0;
    logic reset_n;
    logic flush, stall, enable;
    logic [`XLEN-1:0] pc, readData1, readData2, imm, exMemFwd, memWbFwd;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [1:0] aluOp, fwdA, fwdB;
    logic aluSrc, branch, jump, memRead, memWrite, memToReg, regWrite, predictTaken;

    logic [`XLEN-1:0] memPc, memResult, memWriteData, nextPc;
    logic [`REG_ADDR_W-1:0] memRd;
    logic memMemRead, memMemWrite, memMemToReg, memRegWrite, memValid;
    logic branchInst, branchTaken, mispredict;

    logic [`XLEN-1:0] expPc, expResult, expStore, expNextPc;   // Model of the registers
    logic [`REG_ADDR_W-1:0] expRd;
    logic expMemRead, expMemWrite, expMemToReg, expRegWrite, expValid;
    logic expBranchInst, expTaken, expMiss;

    int unsigned checkCount = 0;
    int unsigned errorCount = 0;

    always #4 clk = ~clk;   // 8 ns period

    executeTop UUT (
        .clk (clk), .reset_n (reset_n), .flush (flush), .stall (stall), .enable (enable),
        .pc (pc), .readData1 (readData1), .readData2 (readData2), .imm (imm), .rd (rd),
        .funct7 (funct7), .funct3 (funct3), .aluSrc (aluSrc), .aluOp (aluOp),
        .branch (branch), .jump (jump), .memRead (memRead), .memWrite (memWrite),
        .memToReg (memToReg), .regWrite (regWrite), .predictTaken (predictTaken),
        .fwdA (fwdA), .fwdB (fwdB), .exMemFwd (exMemFwd), .memWbFwd (memWbFwd),
        .memPc (memPc), .memResult (memResult), .memWriteData (memWriteData),
        .memRd (memRd), .memMemRead (memMemRead), .memMemWrite (memMemWrite),
        .memMemToReg (memMemToReg), .memRegWrite (memRegWrite), .memValid (memValid),
        .branchInst (branchInst), .branchTaken (branchTaken), .mispredict (mispredict),
        .nextPc (nextPc)
    );

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkOutputs();
        checkValue("memPc", memPc, expPc);
        checkValue("memResult", memResult, expResult);
        checkValue("memWriteData", memWriteData, expStore);
        checkValue("memRd", 32'(memRd), 32'(expRd));
        checkValue("memMemRead", 32'(memMemRead), 32'(expMemRead));
        checkValue("memMemWrite", 32'(memMemWrite), 32'(expMemWrite));
        checkValue("memMemToReg", 32'(memMemToReg), 32'(expMemToReg));
        checkValue("memRegWrite", 32'(memRegWrite), 32'(expRegWrite));
        checkValue("memValid", 32'(memValid), 32'(expValid));
        checkValue("branchInst", 32'(branchInst), 32'(expBranchInst));
        checkValue("branchTaken", 32'(branchTaken), 32'(expTaken));
        checkValue("mispredict", 32'(mispredict), 32'(expMiss));
        checkValue("nextPc", nextPc, expNextPc);
    endtask

    // Forwarding mux, code 3 falls back to register data
    function automatic logic [31:0] selectSource(input logic [1:0] sel, input logic [31:0] regVal,
                                                 input logic [31:0] wbVal, input logic [31:0] memVal);
        if (sel == 2'd2) return memVal;         // EX/MEM
        if (sel == 2'd1) return wbVal;          // MEM/WB
        return regVal;
    endfunction

    function automatic logic [31:0] aluResult(input logic [1:0] op, input logic [2:0] f3,
                                              input logic [6:0] f7, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];                            // Shift amount from low bits
        r  = a + b;                             // Load/store address
        if (op == ALUOP_BRANCH) begin
            r = a - b;
        end else if (op == ALUOP_RTYPE || op == ALUOP_ITYPE) begin
            case (f3)
                3'b000:  r = (op == ALUOP_RTYPE && f7[5]) ? a - b : a + b;
                3'b001:  r = a << sh;
                3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  r = (a < b) ? 32'd1 : 32'd0;
                3'b100:  r = a ^ b;
                3'b101:  r = f7[5] ? $unsigned($signed(a) >>> sh) : a >> sh;
                3'b110:  r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    function automatic logic branchCondition(input logic [2:0] f3, input logic [31:0] x,
                                             input logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;               // 010 and 011 never branch
        endcase
    endfunction

    function automatic logic [2:0] branchCode(input logic [2:0] k);
        case (k)
            3'd0:    return 3'b000;
            3'd1:    return 3'b001;
            3'd2:    return 3'b100;
            3'd3:    return 3'b101;
            3'd4:    return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    task automatic clearModel();
        {expPc, expResult, expStore, expRd} = '0;
        {expMemRead, expMemWrite, expMemToReg, expRegWrite, expValid} = '0;
        {expBranchInst, expTaken, expMiss, expNextPc} = '0;
    endtask

    // Next register state at a rising edge; flush over stall over enable
    task automatic updateModel();
        logic [31:0] a, rs2v, b;
        logic        taken;
        a    = selectSource(fwdA, readData1, memWbFwd, exMemFwd);
        rs2v = selectSource(fwdB, readData2, memWbFwd, exMemFwd);
        b    = aluSrc ? imm : rs2v;             // Immediate wins
        if (flush) begin
            clearModel();
        end else if (stall) begin
            expValid = 1'b0;                    // Everything else held
        end else begin
            {expBranchInst, expTaken, expMiss, expNextPc} = '0;
            if (enable && (branch || jump)) begin
                taken         = jump || (branch && branchCondition(funct3, a, rs2v));
                expBranchInst = branch && !jump;
                expTaken      = taken;
                expMiss       = taken != predictTaken;
                if (expMiss) expNextPc = taken ? pc + imm : pc + 32'(`INSTR_STEP);
            end
            expValid = enable;                  // Payload held on a bubble
            if (enable) begin
                expPc       = pc;
                expResult   = jump ? pc + 32'(`INSTR_STEP) : aluResult(aluOp, funct3, funct7, a, b);
                expStore    = rs2v;             // Forwarded rs2
                expRd       = rd;
                expMemRead  = memRead;
                expMemWrite = memWrite;
                expMemToReg = memToReg;
                expRegWrite = regWrite;
            end
        end
    endtask

    task automatic randomizeInputs();
        int unsigned pick;
        logic [31:0] r;
        if (stall && !flush) begin              // Upstream holds the stalled instruction
            stall = ($urandom % 100) < 10;
            flush = ($urandom % 100) < 10;
            return;
        end
        pick = $urandom % 100;                  // Instruction class
        r    = $urandom;
        {enable, branch, jump, memRead, memWrite, memToReg, regWrite, aluSrc} = 8'b1000_0000;
        pc           = $urandom & 32'hffff_fffc;
        readData1    = $urandom;
        readData2    = $urandom;
        exMemFwd     = $urandom;
        memWbFwd     = $urandom;
        if (r[21:20] == 2'b00) begin            // Equal operands for BEQ/BGE edges
            readData2 = readData1;
            exMemFwd  = readData1;
            memWbFwd  = readData1;
        end
        imm          = {{20{r[11]}}, r[11:0]};
        rd           = 5'($urandom);
        funct7       = r[12] ? 7'h20 : 7'h00;
        funct3       = r[15:13];
        predictTaken = r[16];
        fwdA         = r[18:17];
        fwdB         = r[23:22];
        aluOp        = ALUOP_LS;
        if (pick < 20) begin                    // R-type
            aluOp    = ALUOP_RTYPE;
            regWrite = 1'b1;
        end else if (pick < 40) begin           // I-type
            aluOp    = ALUOP_ITYPE;
            aluSrc   = 1'b1;
            regWrite = 1'b1;
        end else if (pick < 60) begin           // Conditional branch
            aluOp  = ALUOP_BRANCH;
            branch = 1'b1;
            funct3 = branchCode(3'($urandom % 6));
            imm    = {{19{r[12]}}, r[12:1], 1'b0};
        end else if (pick < 70) begin           // Jump with link
            jump     = 1'b1;
            regWrite = 1'b1;
            imm      = {{19{r[12]}}, r[12:1], 1'b0};
        end else if (pick < 80) begin           // Load
            {aluSrc, memRead, memToReg, regWrite} = 4'b1111;
        end else if (pick < 90) begin           // Store
            aluSrc   = 1'b1;
            memWrite = 1'b1;
        end else begin
            enable = 1'b0;                      // Bubble
        end
        stall = ($urandom % 100) < 10;
        flush = ($urandom % 100) < 10;
    endtask

    initial begin
        void'($urandom(32'hac4d_0996));
        reset_n = 1'b0;
        {flush, stall, enable, aluSrc, branch, jump, predictTaken} = '0;
        {memRead, memWrite, memToReg, regWrite} = '0;
        {pc, readData1, readData2, imm, exMemFwd, memWbFwd} = '0;
        {rd, funct7, funct3, aluOp, fwdA, fwdB} = '0;
        clearModel();
        repeat (5) @(posedge clk);              // Reset for 5 cycles
        @(negedge clk);
        reset_n = 1'b1;
        checkOutputs();                         // Reset state before any enable
        for (int i = 0; i < NUM_CYCLES; i++) begin
            randomizeInputs();                  // Falling edge drive
            @(posedge clk);
            updateModel();
            @(negedge clk);
            checkOutputs();                     // Outputs stable mid-cycle
        end
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/rvIsaPkg.sv
hw/exPipePkg.sv
hw/aluIf.sv
hw/aluDecoder.sv
hw/alu.sv
hw/branchResolver.sv
hw/stageReg.sv
hw/executeStage.sv
hw/executeTop.sv
test/tbExecute.sv

/* run.sh */
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tbExecute -o simExecute \
    && ./obj_dir/simExecute | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "Simulation result: passed" \
    || { echo "Simulation result: failed"; exit 1; }
